/* logic/dbg_pkg.sv */
/*
 * Shared widths, DMI payload types, register map and timing constants
 * for the debug-access harness. Used by the RTL and the testbench.
 */

package dbg_pkg;

  // ------------------------------------------------------------
  // DMI widths and payloads
  // ------------------------------------------------------------
  localparam int unsigned DmiAddrWidth = 7;
  localparam int unsigned DmiDataWidth = 32;

  typedef enum logic [1:0] {
    DTM_NOP   = 2'd0,
    DTM_READ  = 2'd1,
    DTM_WRITE = 2'd2,
    DTM_RSVD  = 2'd3
  } dtm_op_e;

  typedef struct packed {
    logic [DmiAddrWidth-1:0] addr;
    dtm_op_e                 op;
    logic [DmiDataWidth-1:0] data;
  } dmi_req_t;

  typedef struct packed {
    logic [1:0]              resp;
    logic [DmiDataWidth-1:0] data;
  } dmi_resp_t;

  localparam logic [1:0] RespSuccess = 2'd0;
  localparam logic [1:0] RespFailed  = 2'd2;

  // ------------------------------------------------------------
  // Register map
  // ------------------------------------------------------------
  localparam logic [DmiAddrWidth-1:0] AddrData0     = 7'h04;
  localparam logic [DmiAddrWidth-1:0] AddrDmControl = 7'h10;

  localparam int unsigned HaltReqBit  = 31;
  localparam int unsigned NdmResetBit = 1;

  // Buffering and in-flight tracking
  localparam int unsigned FifoDepth        = 2;
  localparam int unsigned OutstandingWidth = 3;

  // Halt requests are masked this long after power-on reset
  localparam int unsigned DebugDelayCycles = 32;

endpackage

/* logic/dmi_if.sv */
/*
 * DMI request/response channel pair with valid/ready on each side.
 * The requester drives requests, the responder drives responses.
 */

`timescale 1ns/10ps

interface dmi_if;

  logic                 req_valid;
  logic                 req_ready;
  dbg_pkg::dmi_req_t    req;
  logic                 resp_valid;
  logic                 resp_ready;
  dbg_pkg::dmi_resp_t   resp;

  modport requester (
    output req_valid, req, resp_ready,
    input  req_ready, resp_valid, resp
  );

  modport responder (
    input  req_valid, req, resp_ready,
    output req_ready, resp_valid, resp
  );

endinterface

/* logic/dmi_fifo.sv */
/*
 * Small valid/ready FIFO on a generic payload type. Used once for DMI
 * requests and once for DMI responses; no fall-through path.
 */

`timescale 1ns/10ps

module dmi_fifo #(
  parameter type         payload_t = logic,
  parameter int unsigned Depth     = dbg_pkg::FifoDepth
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     in_valid_i,
  output logic     in_ready_o,
  input  payload_t in_data_i,
  output logic     out_valid_o,
  input  logic     out_ready_i,
  output payload_t out_data_o
);

  localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntWidth = $clog2(Depth + 1);

  payload_t              mem_q [Depth];
  logic [PtrWidth-1:0]   wr_ptr_q, rd_ptr_q;
  logic [CntWidth-1:0]   cnt_q;
  logic                  push, pop;

  assign in_ready_o  = (cnt_q != CntWidth'(Depth));
  assign out_valid_o = (cnt_q != '0);
  assign out_data_o  = mem_q[rd_ptr_q];

  assign push = in_valid_i & in_ready_o;
  assign pop  = out_valid_o & out_ready_i;

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= in_data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PtrWidth'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrWidth'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (!push && pop) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

endmodule

/* logic/dmi_source_mux.sv */
/*
 * Selects between the JTAG and DTM debug sources. The selection is only
 * re-sampled while nothing is in flight, so responses go back to the issuer.
 */

`timescale 1ns/10ps

module dmi_source_mux (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               jtag_sel_i,
  input  logic               jtag_req_valid_i,
  input  logic               dtm_req_valid_i,
  input  dbg_pkg::dmi_req_t  jtag_req_i,
  input  dbg_pkg::dmi_req_t  dtm_req_i,
  output logic               jtag_req_ready_o,
  output logic               dtm_req_ready_o,
  output logic               jtag_resp_valid_o,
  output logic               dtm_resp_valid_o,
  input  logic               jtag_resp_ready_i,
  input  logic               dtm_resp_ready_i,
  output dbg_pkg::dmi_resp_t resp_o,
  dmi_if.requester           bus
);

  logic [dbg_pkg::OutstandingWidth-1:0] cnt_d, cnt_q;
  logic jtag_act, jtag_act_q;
  logic cnt_full;
  logic req_fire, resp_fire;

  // New selection only when idle
  assign jtag_act = (cnt_q == '0) ? jtag_sel_i : jtag_act_q;
  assign cnt_full = &cnt_q;

  assign bus.req_valid  = (jtag_act ? jtag_req_valid_i : dtm_req_valid_i) & ~cnt_full;
  assign bus.req        = jtag_act ? jtag_req_i : dtm_req_i;
  assign bus.resp_ready = jtag_act ? jtag_resp_ready_i : dtm_resp_ready_i;

  assign jtag_req_ready_o  = jtag_act & bus.req_ready & ~cnt_full;
  assign dtm_req_ready_o   = ~jtag_act & bus.req_ready & ~cnt_full;
  assign jtag_resp_valid_o = jtag_act & bus.resp_valid;
  assign dtm_resp_valid_o  = ~jtag_act & bus.resp_valid;
  assign resp_o            = bus.resp;

  assign req_fire  = bus.req_valid & bus.req_ready;
  assign resp_fire = bus.resp_valid & bus.resp_ready;

  always_comb begin
    cnt_d = cnt_q;
    if (req_fire && !resp_fire) begin
      cnt_d = cnt_q + 1'b1;
    end else if (!req_fire && resp_fire) begin
      cnt_d = cnt_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q      <= '0;
      jtag_act_q <= 1'b0;
    end else begin
      cnt_q      <= cnt_d;
      jtag_act_q <= jtag_act;
    end
  end

endmodule

/* logic/dm_regs.sv */
/*
 * Reduced debug module register file behind the DMI. Handles one request
 * at a time; the response is valid the cycle after the request is taken.
 */

`timescale 1ns/10ps

module dm_regs (
  input  logic     clk_i,
  input  logic     rst_ni,
  dmi_if.responder bus,
  output logic     haltreq_o,
  output logic     ndmreset_o
);

  logic                                 pending_q;
  dbg_pkg::dmi_resp_t                   resp_d, resp_q;
  logic [dbg_pkg::DmiDataWidth-1:0]     data0_q;
  logic [dbg_pkg::DmiDataWidth-1:0]     dmcontrol;
  logic                                 haltreq_q, ndmreset_q;
  logic                                 req_fire, wr_en;

  assign bus.req_ready  = ~pending_q;
  assign bus.resp_valid = pending_q;
  assign bus.resp       = resp_q;

  assign req_fire = bus.req_valid & ~pending_q;
  assign wr_en    = req_fire & (bus.req.op == dbg_pkg::DTM_WRITE);

  // Only the two control bits are implemented
  always_comb begin
    dmcontrol                       = '0;
    dmcontrol[dbg_pkg::HaltReqBit]  = haltreq_q;
    dmcontrol[dbg_pkg::NdmResetBit] = ndmreset_q;
  end

  always_comb begin
    resp_d.resp = dbg_pkg::RespSuccess;
    resp_d.data = '0;
    case (bus.req.op)
      dbg_pkg::DTM_READ: begin
        if (bus.req.addr == dbg_pkg::AddrData0) begin
          resp_d.data = data0_q;
        end else if (bus.req.addr == dbg_pkg::AddrDmControl) begin
          resp_d.data = dmcontrol;
        end
      end
      dbg_pkg::DTM_RSVD: resp_d.resp = dbg_pkg::RespFailed;
      default: ;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      resp_q <= resp_d;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q  <= 1'b0;
      data0_q    <= '0;
      haltreq_q  <= 1'b0;
      ndmreset_q <= 1'b0;
    end else begin
      if (req_fire) begin
        pending_q <= 1'b1;
      end else if (bus.resp_ready) begin
        pending_q <= 1'b0;
      end
      if (wr_en && bus.req.addr == dbg_pkg::AddrData0) begin
        data0_q <= bus.req.data;
      end
      if (wr_en && bus.req.addr == dbg_pkg::AddrDmControl) begin
        haltreq_q  <= bus.req.data[dbg_pkg::HaltReqBit];
        ndmreset_q <= bus.req.data[dbg_pkg::NdmResetBit];
      end
    end
  end

  assign haltreq_o  = haltreq_q;
  assign ndmreset_o = ndmreset_q;

endmodule

/* logic/hart_ctrl.sv */
/*
 * Hart-side debug controls: halt request masked after power-on reset,
 * and the system reset released through a two-flop synchronizer.
 */

`timescale 1ns/10ps

module hart_ctrl (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic haltreq_i,
  input  logic ndmreset_i,
  input  logic debug_enable_i,
  output logic debug_req_o,
  output logic sys_rst_no
);

  localparam int unsigned CntWidth = $clog2(dbg_pkg::DebugDelayCycles + 1);

  logic [CntWidth-1:0] del_cnt_q;
  logic                sys_rst_n;
  logic [1:0]          sync_q;

  // Delay window so the hart can boot before the first halt
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      del_cnt_q <= CntWidth'(dbg_pkg::DebugDelayCycles);
    end else if (del_cnt_q != '0) begin
      del_cnt_q <= del_cnt_q - 1'b1;
    end
  end

  assign debug_req_o = haltreq_i & debug_enable_i & (del_cnt_q == '0);

  // Assert asynchronously, release on the clock
  assign sys_rst_n = rst_ni & ~ndmreset_i;

  always_ff @(posedge clk_i or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      sync_q <= 2'b00;
    end else begin
      sync_q <= {sync_q[0], 1'b1};
    end
  end

  assign sys_rst_no = sync_q[1];

endmodule

/* logic/dbg_harness_top.sv */
/*
 * Debug-access path of the harness: two DMI sources share one register
 * file through request/response FIFOs, plus the hart-side controls.
 */

`timescale 1ns/10ps

module dbg_harness_top (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                jtag_sel_i,
  input  logic                                debug_enable_i,
  // JTAG-side DMI
  input  logic                                jtag_req_valid_i,
  input  logic [dbg_pkg::DmiAddrWidth-1:0]    jtag_req_addr_i,
  input  logic [1:0]                          jtag_req_op_i,
  input  logic [dbg_pkg::DmiDataWidth-1:0]    jtag_req_data_i,
  input  logic                                jtag_resp_ready_i,
  output logic                                jtag_req_ready_o,
  output logic                                jtag_resp_valid_o,
  // DTM-side DMI
  input  logic                                dtm_req_valid_i,
  input  logic [dbg_pkg::DmiAddrWidth-1:0]    dtm_req_addr_i,
  input  logic [1:0]                          dtm_req_op_i,
  input  logic [dbg_pkg::DmiDataWidth-1:0]    dtm_req_data_i,
  input  logic                                dtm_resp_ready_i,
  output logic                                dtm_req_ready_o,
  output logic                                dtm_resp_valid_o,
  // Shared response and hart side
  output logic [1:0]                          resp_code_o,
  output logic [dbg_pkg::DmiDataWidth-1:0]    resp_data_o,
  output logic                                debug_req_o,
  output logic                                sys_rst_no
);

  dbg_pkg::dmi_req_t  jtag_req, dtm_req;
  dbg_pkg::dmi_resp_t resp;
  logic               haltreq, ndmreset;

  dmi_if src_bus ();
  dmi_if dm_bus ();

  assign jtag_req.addr = jtag_req_addr_i;
  assign jtag_req.op   = dbg_pkg::dtm_op_e'(jtag_req_op_i);
  assign jtag_req.data = jtag_req_data_i;
  assign dtm_req.addr  = dtm_req_addr_i;
  assign dtm_req.op    = dbg_pkg::dtm_op_e'(dtm_req_op_i);
  assign dtm_req.data  = dtm_req_data_i;

  assign resp_code_o = resp.resp;
  assign resp_data_o = resp.data;

  // ------------------------------------------------------------
  // Source selection
  // ------------------------------------------------------------
  dmi_source_mux i_source_mux (
    .clk_i             ( clk_i             ),
    .rst_ni            ( rst_ni            ),
    .jtag_sel_i        ( jtag_sel_i        ),
    .jtag_req_valid_i  ( jtag_req_valid_i  ),
    .dtm_req_valid_i   ( dtm_req_valid_i   ),
    .jtag_req_i        ( jtag_req          ),
    .dtm_req_i         ( dtm_req           ),
    .jtag_req_ready_o  ( jtag_req_ready_o  ),
    .dtm_req_ready_o   ( dtm_req_ready_o   ),
    .jtag_resp_valid_o ( jtag_resp_valid_o ),
    .dtm_resp_valid_o  ( dtm_resp_valid_o  ),
    .jtag_resp_ready_i ( jtag_resp_ready_i ),
    .dtm_resp_ready_i  ( dtm_resp_ready_i  ),
    .resp_o            ( resp              ),
    .bus               ( src_bus           )
  );

  // ------------------------------------------------------------
  // Buffering
  // ------------------------------------------------------------
  dmi_fifo #(
    .payload_t   ( dbg_pkg::dmi_req_t )
  ) req_fifo (
    .clk_i       ( clk_i              ),
    .rst_ni      ( rst_ni             ),
    .in_valid_i  ( src_bus.req_valid  ),
    .in_ready_o  ( src_bus.req_ready  ),
    .in_data_i   ( src_bus.req        ),
    .out_valid_o ( dm_bus.req_valid   ),
    .out_ready_i ( dm_bus.req_ready   ),
    .out_data_o  ( dm_bus.req         )
  );

  dmi_fifo #(
    .payload_t   ( dbg_pkg::dmi_resp_t )
  ) resp_fifo (
    .clk_i       ( clk_i               ),
    .rst_ni      ( rst_ni              ),
    .in_valid_i  ( dm_bus.resp_valid   ),
    .in_ready_o  ( dm_bus.resp_ready   ),
    .in_data_i   ( dm_bus.resp         ),
    .out_valid_o ( src_bus.resp_valid  ),
    .out_ready_i ( src_bus.resp_ready  ),
    .out_data_o  ( src_bus.resp        )
  );

  // ------------------------------------------------------------
  // Debug module and hart side
  // ------------------------------------------------------------
  dm_regs i_dm_regs (
    .clk_i      ( clk_i    ),
    .rst_ni     ( rst_ni   ),
    .bus        ( dm_bus   ),
    .haltreq_o  ( haltreq  ),
    .ndmreset_o ( ndmreset )
  );

  hart_ctrl i_hart_ctrl (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .haltreq_i      ( haltreq        ),
    .ndmreset_i     ( ndmreset       ),
    .debug_enable_i ( debug_enable_i ),
    .debug_req_o    ( debug_req_o    ),
    .sys_rst_no     ( sys_rst_no     )
  );

endmodule

/* verif/tb_checker.sv */
/*
 * Watches the harness ports and compares them with a model of the DM
 * registers, the source routing and the hart-side outputs. Expected
 * responses are queued in issue order, tagged with their source.
 */

`timescale 1ns/10ps

module tb_checker (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        jtag_sel_i,
  input  logic        debug_enable_i,
  // Index 1 is the JTAG source, index 0 the DTM source
  input  logic [1:0]  req_valid_i,
  input  logic [1:0]  req_ready_i,
  input  logic [1:0]  resp_valid_i,
  input  logic [1:0]  resp_ready_i,
  input  logic [40:0] jtag_req_i,
  input  logic [40:0] dtm_req_i,
  input  logic [1:0]  resp_code_i,
  input  logic [31:0] resp_data_i,
  input  logic        debug_req_i,
  input  logic        sys_rst_ni,
  output int          err_cnt_o,
  output int          pend_cnt_o
);

  logic [34:0] exp_q [$];
  logic [31:0] data0_m;
  logic        halt_m, ndm_m, act_q;
  int unsigned since_rst;
  int          rel_cnt;

  task automatic compare_value(input string name, input logic [33:0] exp, input logic [33:0] got);
    if (exp !== got) begin
      $display("mismatch %s: expected %h got %h", name, exp, got);
      err_cnt_o++;
    end
  endtask

  task automatic report_error(input string msg);
    $display("error: %s", msg);
    err_cnt_o++;
  endtask

  // Register model applied in the order requests are accepted
  function automatic logic [33:0] model_request(input logic [40:0] req);
    logic [6:0]  addr;
    logic [1:0]  op;
    logic [31:0] data;
    logic [31:0] rdata;
    addr  = req[40:34];
    op    = req[33:32];
    data  = req[31:0];
    rdata = 32'h0;
    if (op == 2'd3) begin
      return {2'd2, 32'h0};
    end
    if (op == 2'd1 && addr == 7'h04) begin
      rdata = data0_m;
    end else if (op == 2'd1 && addr == 7'h10) begin
      rdata = {halt_m, 29'h0, ndm_m, 1'b0};
    end else if (op == 2'd2 && addr == 7'h04) begin
      data0_m = data;
    end else if (op == 2'd2 && addr == 7'h10) begin
      halt_m = data[31];
      ndm_m  = data[1];
    end
    return {2'd0, rdata};
  endfunction

  // Cycles since reset release up to the mask window length
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      since_rst <= 0;
    end else if (since_rst < dbg_pkg::DebugDelayCycles) begin
      since_rst <= since_rst + 1;
    end
  end

  always @(negedge clk_i) begin
    logic        idle;
    logic        act;
    logic        open;
    logic [34:0] head;
    if (!rst_ni) begin
      exp_q.delete();
      act_q   = 1'b0;
      data0_m = 32'h0;
      halt_m  = 1'b0;
      ndm_m   = 1'b0;
      rel_cnt = 0;
      if (sys_rst_ni || debug_req_i || resp_valid_i != 2'b00) begin
        report_error("outputs not in their reset state while rst_ni is low");
      end
    end else begin
      idle = (exp_q.size() == 0);
      act  = idle ? jtag_sel_i : act_q;
      open = (since_rst >= dbg_pkg::DebugDelayCycles);

      // Hart side is only compared with nothing in flight
      if (idle) begin
        compare_value("debug_req_o", {33'h0, halt_m & debug_enable_i & open},
                      {33'h0, debug_req_i});
      end
      if (idle && ndm_m) begin
        compare_value("sys_rst_no", 34'h0, {33'h0, sys_rst_ni});
      end
      rel_cnt = (idle && !ndm_m) ? rel_cnt + 1 : 0;
      if (rel_cnt >= 3) begin
        compare_value("sys_rst_no", 34'h1, {33'h0, sys_rst_ni});
      end

      if (act && (req_ready_i[0] || resp_valid_i[0])) begin
        report_error("dtm source sees ready or response valid while jtag is active");
      end
      if (!act && (req_ready_i[1] || resp_valid_i[1])) begin
        report_error("jtag source sees ready or response valid while dtm is active");
      end

      for (int s = 0; s < 2; s++) begin
        if (resp_valid_i[s] && resp_ready_i[s]) begin
          if (exp_q.size() == 0) begin
            report_error("response delivered with nothing outstanding");
          end else begin
            head = exp_q.pop_front();
            if (head[34] != s[0]) begin
              report_error("response delivered to a source that did not issue it");
            end
            compare_value("resp_code_o", {32'h0, head[33:32]}, {32'h0, resp_code_i});
            compare_value("resp_data_o", {2'h0, head[31:0]}, {2'h0, resp_data_i});
          end
        end
      end

      if (req_valid_i[1] && req_ready_i[1]) begin
        exp_q.push_back({1'b1, model_request(jtag_req_i)});
      end
      if (req_valid_i[0] && req_ready_i[0]) begin
        exp_q.push_back({1'b0, model_request(dtm_req_i)});
      end
      act_q = act;
    end
    pend_cnt_o = exp_q.size();
  end

endmodule

/* verif/tb_top.sv */
/*
 * Testbench for the debug-access harness. Drives both DMI sources with
 * LFSR stimulus and directed sequences; tb_checker does the comparing.
 */

`timescale 1ns/10ps

module tb_top;

  localparam int unsigned RandCycles    = 3000;
  localparam int unsigned BpCycles      = 40;
  localparam int unsigned HaltCycles    = 120;
  localparam int unsigned TimeoutCycles = 2 * (RandCycles + BpCycles + HaltCycles) + 500;

  logic        clk_i, rst_ni, jtag_sel_i, debug_enable_i;
  logic        jtag_req_valid_i, jtag_resp_ready_i, jtag_req_ready_o, jtag_resp_valid_o;
  logic [6:0]  jtag_req_addr_i;
  logic [1:0]  jtag_req_op_i;
  logic [31:0] jtag_req_data_i;
  logic        dtm_req_valid_i, dtm_resp_ready_i, dtm_req_ready_o, dtm_resp_valid_o;
  logic [6:0]  dtm_req_addr_i;
  logic [1:0]  dtm_req_op_i;
  logic [31:0] dtm_req_data_i;
  logic [1:0]  resp_code_o;
  logic [31:0] resp_data_o;
  logic        debug_req_o, sys_rst_no;

  logic [31:0] lfsr;
  int          cycles, tb_errs, chk_errs, pending;
  int          tests_run, tests_failed, err_mark;

  dbg_harness_top dut0 (.*);

  tb_checker chk0 (
    .clk_i          ( clk_i                                          ),
    .rst_ni         ( rst_ni                                         ),
    .jtag_sel_i     ( jtag_sel_i                                     ),
    .debug_enable_i ( debug_enable_i                                 ),
    .req_valid_i    ( {jtag_req_valid_i, dtm_req_valid_i}            ),
    .req_ready_i    ( {jtag_req_ready_o, dtm_req_ready_o}            ),
    .resp_valid_i   ( {jtag_resp_valid_o, dtm_resp_valid_o}          ),
    .resp_ready_i   ( {jtag_resp_ready_i, dtm_resp_ready_i}          ),
    .jtag_req_i     ( {jtag_req_addr_i, jtag_req_op_i, jtag_req_data_i} ),
    .dtm_req_i      ( {dtm_req_addr_i, dtm_req_op_i, dtm_req_data_i}    ),
    .resp_code_i    ( resp_code_o                                    ),
    .resp_data_i    ( resp_data_o                                    ),
    .debug_req_i    ( debug_req_o                                    ),
    .sys_rst_ni     ( sys_rst_no                                     ),
    .err_cnt_o      ( chk_errs                                       ),
    .pend_cnt_o     ( pending                                        )
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= TimeoutCycles) begin
      $display("timeout: run did not finish within %0d cycles", TimeoutCycles);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  // Galois LFSR stepped once per bit taken
  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] r;
    r = 32'h0;
    for (int unsigned i = 0; i < n; i++) begin
      r    = {r[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return r;
  endfunction

  task automatic draw_request(output logic valid, output logic [6:0] addr,
                              output logic [1:0] op, output logic [31:0] data);
    logic [31:0] r;
    r     = rand_bits(2);
    valid = (r != 0);
    r     = rand_bits(2);
    case (r[1:0])
      2'd0, 2'd1: addr = dbg_pkg::AddrData0;
      2'd2:       addr = dbg_pkg::AddrDmControl;
      default:    addr = 7'h20;
    endcase
    r    = rand_bits(2);
    op   = r[1:0];
    data = rand_bits(32);
  endtask

  task automatic apply_reset();
    rst_ni            = 1'b0;
    jtag_req_valid_i  = 1'b0;
    dtm_req_valid_i   = 1'b0;
    jtag_resp_ready_i = 1'b1;
    dtm_resp_ready_i  = 1'b1;
    repeat (4) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
  endtask

  // One clock of random traffic; a pending request is held until taken
  task automatic random_cycle(input logic hold_back, output logic jtag_rdy);
    logic        jtag_fire, dtm_fire;
    logic [31:0] r;
    @(negedge clk_i);
    jtag_rdy  = jtag_req_ready_o;
    jtag_fire = jtag_req_valid_i & jtag_req_ready_o;
    dtm_fire  = dtm_req_valid_i & dtm_req_ready_o;
    @(posedge clk_i);
    #1;
    if (!jtag_req_valid_i || jtag_fire) begin
      draw_request(jtag_req_valid_i, jtag_req_addr_i, jtag_req_op_i, jtag_req_data_i);
    end
    if (!dtm_req_valid_i || dtm_fire) begin
      draw_request(dtm_req_valid_i, dtm_req_addr_i, dtm_req_op_i, dtm_req_data_i);
    end
    r = rand_bits(4);
    if (r == 0) jtag_sel_i = ~jtag_sel_i;
    r = rand_bits(2);
    jtag_resp_ready_i = (r != 0);
    r = rand_bits(2);
    dtm_resp_ready_i = (r != 0);
    r = rand_bits(6);
    if (r == 0) debug_enable_i = ~debug_enable_i;
    if (hold_back) begin
      jtag_sel_i        = 1'b1;
      jtag_resp_ready_i = 1'b0;
      dtm_req_valid_i   = 1'b0;
    end
  endtask

  // Finish pending requests and collect every response
  task automatic drain();
    logic jtag_fire, dtm_fire;
    while (jtag_req_valid_i || dtm_req_valid_i || pending != 0) begin
      @(negedge clk_i);
      jtag_fire = jtag_req_valid_i & jtag_req_ready_o;
      dtm_fire  = dtm_req_valid_i & dtm_req_ready_o;
      @(posedge clk_i);
      #1;
      if (jtag_fire) jtag_req_valid_i = 1'b0;
      if (dtm_fire) dtm_req_valid_i = 1'b0;
      jtag_sel_i        = jtag_req_valid_i;
      jtag_resp_ready_i = 1'b1;
      dtm_resp_ready_i  = 1'b1;
    end
  endtask

  task automatic send_jtag(input logic [6:0] addr, input logic [1:0] op, input logic [31:0] data);
    @(posedge clk_i);
    #1;
    jtag_sel_i        = 1'b1;
    jtag_resp_ready_i = 1'b1;
    jtag_req_valid_i  = 1'b1;
    jtag_req_addr_i   = addr;
    jtag_req_op_i     = op;
    jtag_req_data_i   = data;
    @(negedge clk_i);
    while (!jtag_req_ready_o) @(negedge clk_i);
    @(posedge clk_i);
    #1;
    jtag_req_valid_i = 1'b0;
    @(negedge clk_i);
    while (!jtag_resp_valid_o) @(negedge clk_i);
    @(posedge clk_i);
  endtask

  task automatic finish_test(input string name);
    int delta;
    delta = tb_errs + chk_errs - err_mark;
    $display("test %-16s %0d errors", name, delta);
    tests_run++;
    if (delta != 0) tests_failed++;
    err_mark = tb_errs + chk_errs;
  endtask

  // ------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------
  initial begin
    int   waited;
    int   low_run;
    int   total;
    logic rdy;
    lfsr = 32'hb755_dfcf;
    {jtag_sel_i, debug_enable_i} = 2'b01;
    {jtag_req_addr_i, jtag_req_op_i, jtag_req_data_i} = '0;
    {dtm_req_addr_i, dtm_req_op_i, dtm_req_data_i} = '0;
    {tb_errs, tests_run, tests_failed, err_mark} = '0;
    apply_reset();

    waited = 0;
    while (!sys_rst_no && waited < 4) begin
      @(negedge clk_i);
      waited++;
    end
    if (!sys_rst_no) begin
      $display("mismatch sys_rst_no: expected 1 got %h", sys_rst_no);
      tb_errs++;
    end
    finish_test("reset");

    repeat (RandCycles) random_cycle(1'b0, rdy);
    drain();
    finish_test("random_traffic");

    // Responses held back until the request side stalls
    waited  = 0;
    low_run = 0;
    while (low_run < 8 && waited < BpCycles) begin
      random_cycle(1'b1, rdy);
      low_run = rdy ? 0 : low_run + 1;
      waited++;
    end
    if (low_run < 8) begin
      $display("error: jtag request ready never fell while its responses were held");
      tb_errs++;
    end
    drain();
    finish_test("back_pressure");

    apply_reset();
    debug_enable_i = 1'b1;
    send_jtag(dbg_pkg::AddrDmControl, 2'd2, 32'h8000_0000);
    repeat (40) @(posedge clk_i);
    #1;
    debug_enable_i = 1'b0;
    repeat (5) @(posedge clk_i);
    #1;
    debug_enable_i = 1'b1;
    send_jtag(dbg_pkg::AddrDmControl, 2'd2, 32'h8000_0002);
    send_jtag(dbg_pkg::AddrDmControl, 2'd1, 32'h0);
    send_jtag(dbg_pkg::AddrDmControl, 2'd2, 32'h0);
    repeat (4) @(posedge clk_i);
    finish_test("halt_and_reset");

    total = tb_errs + chk_errs;
    $display("summary: %0d tests run, %0d failed, %0d errors", tests_run, tests_failed, total);
    if (total == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

/* all.f */
logic/dbg_pkg.sv
logic/dmi_if.sv
logic/dmi_fifo.sv
logic/dmi_source_mux.sv
logic/dm_regs.sv
logic/hart_ctrl.sv
logic/dbg_harness_top.sv
verif/tb_checker.sv
verif/tb_top.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_top
FILELIST   := all.f
BUILD_DIR  := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only --timing --top-module $(TOP)
SIM_FLAGS  := --binary --timing --top-module $(TOP) --Mdir $(BUILD_DIR)

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qF '*** TEST FAILED ***' $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -qF '*** TEST PASSED ***' $(LOG) || (echo "no pass result in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
